/* hw/board_macros.svh */
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

////////////////////
// Chip array and report format
////////////////////

// Chips on the board, one result byte each
`define BOARD_NUM_CHIPS 16
`define BOARD_BYTE_W 8

// Separator after every byte of the report
`define BOARD_NEWLINE 8'h0A

////////////////////
// Default timing at 100 MHz
////////////////////

// About 10 ms of stable input
`define BOARD_DEBOUNCE_CYCLES 1048576

// LED hold, about 5 s
`define BOARD_HOLD_CYCLES 500000000

// 100 MHz / 868, close to 115200 baud
`define BOARD_BAUD_DIV 868

`endif

/* hw/board_pkg.sv */
`include "board_macros.svh"

package board_pkg;

    ////////////////////
    // Chip array results
    ////////////////////

    // One chip's compute result
    typedef logic [`BOARD_BYTE_W-1:0] chip_byte_t;

    // All chip results side by side
    // Element 0 holds chip 1, element 15 holds chip 16
    typedef chip_byte_t [`BOARD_NUM_CHIPS-1:0] chip_bytes_t;

endpackage

/* hw/uart_pkg.sv */
`include "board_macros.svh"

package uart_pkg;

    ////////////////////
    // Serial link
    ////////////////////

    typedef logic [`BOARD_BYTE_W-1:0] uart_byte_t;

    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_t;

    ////////////////////
    // Report layout
    ////////////////////

    // Chip byte plus newline for every chip
    localparam int REPORT_LEN = 2 * `BOARD_NUM_CHIPS;

    typedef logic [$clog2(REPORT_LEN)-1:0] report_idx_t;

endpackage

/* hw/btn_debounce.sv */
`timescale 1ns/1ps
`include "board_macros.svh"

module btn_debounce #(
    parameter int DEBOUNCE_CYCLES = `BOARD_DEBOUNCE_CYCLES
) (
    input  logic clk_100m,
    input  logic rst_n_locked,
    input  logic button,
    output logic press
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic             btn_sync0;
    logic             btn_sync1;
    logic [CNT_W-1:0] stable_cnt;
    logic             btn_state;
    logic             btn_state_d;

    // Button is active low, invert before the synchronizer
    always_ff @(posedge clk_100m or negedge rst_n_locked) begin
        if (!rst_n_locked) begin
            btn_sync0 <= 1'b0;
            btn_sync1 <= 1'b0;
        end else begin
            btn_sync0 <= ~button;
            btn_sync1 <= btn_sync0;
        end
    end

    // Flip state only after a full run of disagreeing samples
    always_ff @(posedge clk_100m or negedge rst_n_locked) begin
        if (!rst_n_locked) begin
            stable_cnt  <= '0;
            btn_state   <= 1'b0;
            btn_state_d <= 1'b0;
        end else begin
            btn_state_d <= btn_state;
            if (btn_sync1 != btn_state) begin
                if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                    btn_state  <= btn_sync1;
                    stable_cnt <= '0;
                end else begin
                    stable_cnt <= stable_cnt + 1'b1;
                end
            end else begin
                stable_cnt <= '0;
            end
        end
    end

    assign press = btn_state & ~btn_state_d;

    a_press_single : assert property (
        @(posedge clk_100m) disable iff (!rst_n_locked) press |=> !press
    );

endmodule

/* hw/done_led_hold.sv */
`timescale 1ns/1ps
`include "board_macros.svh"

module done_led_hold #(
    parameter int HOLD_CYCLES = `BOARD_HOLD_CYCLES
) (
    input  logic clk_100m,
    input  logic rst_n_locked,
    input  logic done,
    output logic led
);

    localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

    logic [CNT_W-1:0] hold_cnt;

    // Retriggerable, a new strobe reloads the full hold
    always_ff @(posedge clk_100m or negedge rst_n_locked) begin
        if (!rst_n_locked) begin
            hold_cnt <= '0;
        end else if (done) begin
            hold_cnt <= CNT_W'(HOLD_CYCLES);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign led = (hold_cnt != '0);

    a_hold_range : assert property (
        @(posedge clk_100m) disable iff (!rst_n_locked)
        hold_cnt <= CNT_W'(HOLD_CYCLES)
    );

endmodule

/* hw/report_sequencer.sv */
`timescale 1ns/1ps
`include "board_macros.svh"

module report_sequencer (
    input  logic                   clk_100m,
    input  logic                   rst_n_locked,
    input  logic                   rd_done,
    input  board_pkg::chip_bytes_t dram_data,
    input  logic                   tx_busy,
    output logic                   tx_start,
    output uart_pkg::uart_byte_t   tx_byte
);

    import uart_pkg::*;

    localparam int IDX_W = $bits(report_idx_t);

    logic        sending;
    report_idx_t send_idx;
    logic        issue;

    // Next byte goes out once the transmitter is free
    assign issue = sending && !tx_busy;

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge clk_100m or negedge rst_n_locked) begin
        if (!rst_n_locked) begin
            sending  <= 1'b0;
            send_idx <= '0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            if (rd_done && !sending) begin
                sending  <= 1'b1;
                send_idx <= '0;
            end else if (issue) begin
                tx_start <= 1'b1;
                send_idx <= send_idx + 1'b1;
                if (send_idx == report_idx_t'(REPORT_LEN - 1)) begin
                    sending <= 1'b0;
                end
            end
        end
    end

    ////////////////////
    // Byte select
    ////////////////////

    // Even slots carry a chip result, odd slots the separator
    always_ff @(posedge clk_100m) begin
        if (issue) begin
            if (send_idx[0]) begin
                tx_byte <= `BOARD_NEWLINE;
            end else begin
                tx_byte <= dram_data[send_idx[IDX_W-1:1]];
            end
        end
    end

    // tx_busy rises with tx_start, so check the cycle of the decision
    a_no_start_busy : assert property (
        @(posedge clk_100m) disable iff (!rst_n_locked)
        tx_start |-> !$past(tx_busy)
    );

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ps
`include "board_macros.svh"

module uart_tx #(
    parameter int BAUD_DIV = `BOARD_BAUD_DIV
) (
    input  logic                 clk_100m,
    input  logic                 rst_n_locked,
    input  logic                 tx_start,
    input  uart_pkg::uart_byte_t tx_byte,
    output logic                 tx_busy,
    output logic                 txd
);

    import uart_pkg::*;

    localparam int BAUD_W = $clog2(BAUD_DIV + 1);
    localparam int BIT_W  = $clog2($bits(uart_byte_t));

    tx_state_t         state;
    logic [BAUD_W-1:0] baud_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    uart_byte_t        shift_reg;
    logic              bit_end;

    assign bit_end = (baud_cnt == BAUD_W'(BAUD_DIV - 1));

    // Busy from the start strobe until the stop bit is done
    assign tx_busy = tx_start || (state != TX_IDLE);

    ////////////////////
    // Frame FSM
    ////////////////////

    always_ff @(posedge clk_100m or negedge rst_n_locked) begin
        if (!rst_n_locked) begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            txd      <= 1'b1;
        end else begin
            baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    baud_cnt <= '0;
                    if (tx_start) begin
                        state <= TX_START;
                        txd   <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state   <= TX_DATA;
                        bit_cnt <= '0;
                        txd     <= shift_reg[0];
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == BIT_W'($bits(uart_byte_t) - 1)) begin
                            state <= TX_STOP;
                            txd   <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            txd     <= shift_reg[1];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk_100m) begin
        if (state == TX_IDLE && tx_start) begin
            shift_reg <= tx_byte;
        end else if (state == TX_DATA && bit_end) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    a_idle_mark : assert property (
        @(posedge clk_100m) disable iff (!rst_n_locked)
        (state == TX_IDLE) |-> txd
    );

endmodule

/* hw/board_ctrl_top.sv */
`timescale 1ns/1ps
`include "board_macros.svh"

module board_ctrl_top #(
    parameter int DEBOUNCE_CYCLES = `BOARD_DEBOUNCE_CYCLES,
    parameter int HOLD_CYCLES     = `BOARD_HOLD_CYCLES,
    parameter int BAUD_DIV        = `BOARD_BAUD_DIV
) (
    input  logic                   clk_100m,
    input  logic                   rst_n_locked,
    input  logic                   io_en_button,
    input  logic                   rd_done,
    input  logic                   wt_done,
    input  board_pkg::chip_bytes_t dram_data,
    output logic                   io_en,
    output logic                   rd_done_led,
    output logic                   wt_done_led,
    output logic                   uart_txd
);

    import uart_pkg::*;

    logic [1:0] done_vec;
    logic [1:0] led_vec;
    logic       tx_start;
    uart_byte_t tx_byte;
    logic       tx_busy;

    ////////////////////
    // Start button
    ////////////////////

    btn_debounce #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) btn_debounce_i (
        .clk_100m    (clk_100m),
        .rst_n_locked(rst_n_locked),
        .button      (io_en_button),
        .press       (io_en)
    );

    ////////////////////
    // Done LEDs
    ////////////////////

    // Index 0 read done, index 1 write done
    assign done_vec    = {wt_done, rd_done};
    assign rd_done_led = led_vec[0];
    assign wt_done_led = led_vec[1];

    for (genvar i = 0; i < 2; i++) begin : g_led_hold
        done_led_hold #(
            .HOLD_CYCLES(HOLD_CYCLES)
        ) done_led_hold_i (
            .clk_100m    (clk_100m),
            .rst_n_locked(rst_n_locked),
            .done        (done_vec[i]),
            .led         (led_vec[i])
        );
    end

    ////////////////////
    // Serial report
    ////////////////////

    report_sequencer report_sequencer_i (
        .clk_100m    (clk_100m),
        .rst_n_locked(rst_n_locked),
        .rd_done     (rd_done),
        .dram_data   (dram_data),
        .tx_busy     (tx_busy),
        .tx_start    (tx_start),
        .tx_byte     (tx_byte)
    );

    uart_tx #(
        .BAUD_DIV(BAUD_DIV)
    ) uart_tx_i (
        .clk_100m    (clk_100m),
        .rst_n_locked(rst_n_locked),
        .tx_start    (tx_start),
        .tx_byte     (tx_byte),
        .tx_busy     (tx_busy),
        .txd         (uart_txd)
    );

endmodule

/* dv/uart_line_monitor.sv */
`timescale 1ns/1ps
`include "board_macros.svh"

module uart_line_monitor #(
    parameter int BAUD_DIV = 8
) (
    input  logic                     clk_100m,
    input  logic                     rst_n_locked,
    input  logic                     txd,
    output logic                     rx_valid,
    output logic [`BOARD_BYTE_W-1:0] rx_byte,
    output logic                     rx_start_bit,
    output logic                     rx_stop_bit
);

    ////////////////////
    // Frame decoder
    ////////////////////

    // The line moves on rising edges, so every sample is taken on a falling edge
    initial begin
        logic [`BOARD_BYTE_W-1:0] data_sr;
        data_sr      = '0;
        rx_valid     = 1'b0;
        rx_byte      = '0;
        rx_start_bit = 1'b1;
        rx_stop_bit  = 1'b0;
        forever begin
            // Idle line until the start bit
            @(negedge clk_100m);
            while (!rst_n_locked || txd) begin
                @(negedge clk_100m);
            end
            // Middle of the start bit
            repeat (BAUD_DIV / 2) @(negedge clk_100m);
            rx_start_bit = txd;
            // LSB first
            for (int i = 0; i < `BOARD_BYTE_W; i++) begin
                repeat (BAUD_DIV) @(negedge clk_100m);
                data_sr = {txd, data_sr[`BOARD_BYTE_W-1:1]};
            end
            repeat (BAUD_DIV) @(negedge clk_100m);
            rx_stop_bit = txd;
            rx_byte     = data_sr;
            rx_valid    = 1'b1;
            @(negedge clk_100m);
            rx_valid = 1'b0;
        end
    end

endmodule

/* dv/tb_board_ctrl.sv */
`timescale 1ns/1ps
`include "board_macros.svh"

module tb_board_ctrl;

    import board_pkg::*;

    localparam int DEBOUNCE_CYCLES = 16;
    localparam int HOLD_CYCLES     = 50;
    localparam int BAUD_DIV        = 8;
    localparam int REPORT_BYTES    = 2 * `BOARD_NUM_CHIPS;
    localparam int CHIP_W          = $clog2(`BOARD_NUM_CHIPS);
    localparam int TIMEOUT_CYCLES  =
        4 * (REPORT_BYTES * 10 * BAUD_DIV + 2 * HOLD_CYCLES + 8 * DEBOUNCE_CYCLES);

    logic                     clk_100m = 1'b0;
    logic                     rst_n_locked;
    logic                     io_en_button;
    logic                     rd_done;
    logic                     wt_done;
    chip_bytes_t              dram_data;
    logic                     io_en;
    logic                     rd_done_led;
    logic                     wt_done_led;
    logic                     uart_txd;

    logic                     rx_valid;
    logic [`BOARD_BYTE_W-1:0] rx_byte;
    logic                     rx_start_bit;
    logic                     rx_stop_bit;
    logic [`BOARD_BYTE_W-1:0] rx_q[$];

    integer seed;
    int     cycle_cnt   = 0;
    int     io_en_cnt   = 0;
    int     wt_age;
    int     rd_age;
    int     stim_errs   = 0;
    int     led_errs    = 0;
    int     rx_errs     = 0;
    int     pulse_errs  = 0;
    int     strobe_errs = 0;

    always #5 clk_100m = ~clk_100m;

    board_ctrl_top #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
        .HOLD_CYCLES    (HOLD_CYCLES),
        .BAUD_DIV       (BAUD_DIV)
    ) board_ctrl_top_i (
        .clk_100m    (clk_100m),
        .rst_n_locked(rst_n_locked),
        .io_en_button(io_en_button),
        .rd_done     (rd_done),
        .wt_done     (wt_done),
        .dram_data   (dram_data),
        .io_en       (io_en),
        .rd_done_led (rd_done_led),
        .wt_done_led (wt_done_led),
        .uart_txd    (uart_txd)
    );

    uart_line_monitor #(
        .BAUD_DIV(BAUD_DIV)
    ) uart_line_monitor_i (
        .clk_100m    (clk_100m),
        .rst_n_locked(rst_n_locked),
        .txd         (uart_txd),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte),
        .rx_start_bit(rx_start_bit),
        .rx_stop_bit (rx_stop_bit)
    );

    ////////////////////
    // Checkers
    ////////////////////

    // Age 1 is the first lit cycle after a strobe
    function automatic int next_age(input int age, input logic strobe);
        if (strobe) begin
            return 1;
        end
        return (age > HOLD_CYCLES) ? age : age + 1;
    endfunction

    always @(posedge clk_100m or negedge rst_n_locked) begin
        if (!rst_n_locked) begin
            wt_age <= HOLD_CYCLES + 1;
            rd_age <= HOLD_CYCLES + 1;
        end else begin
            wt_age <= next_age(wt_age, wt_done);
            rd_age <= next_age(rd_age, rd_done);
        end
    end

    always @(negedge clk_100m) begin
        if (rst_n_locked) begin
            assert (wt_done_led == (wt_age <= HOLD_CYCLES)) else begin
                led_errs++;
                $display("FAILED wt_led_hold: expected %0b, actual %0b",
                         wt_age <= HOLD_CYCLES, wt_done_led);
            end
            assert (rd_done_led == (rd_age <= HOLD_CYCLES)) else begin
                led_errs++;
                $display("FAILED rd_led_hold: expected %0b, actual %0b",
                         rd_age <= HOLD_CYCLES, rd_done_led);
            end
        end
    end

    always @(posedge clk_100m) begin
        if (rst_n_locked && io_en) begin
            io_en_cnt <= io_en_cnt + 1;
        end
    end

    always @(posedge clk_100m) begin
        if (rx_valid) begin
            rx_q.push_back(rx_byte);
            assert (!rx_start_bit && rx_stop_bit) else begin
                rx_errs++;
                $display("FAILED frame_bits: expected start 0 stop 1, actual start %0b stop %0b",
                         rx_start_bit, rx_stop_bit);
            end
        end
    end

    a_io_en_one_cycle : assert property (
        @(posedge clk_100m) disable iff (!rst_n_locked) io_en |=> !io_en
    ) else begin
        pulse_errs++;
        $display("io_en stayed high for more than one cycle");
    end

    a_wt_led_on : assert property (
        @(posedge clk_100m) disable iff (!rst_n_locked) wt_done |=> wt_done_led
    ) else begin
        strobe_errs++;
        $display("wt_done_led did not light in the cycle after wt_done");
    end

    always @(posedge clk_100m) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_100m);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            stim_errs++;
            $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic check_idle_outputs(input string name);
        check_value({name, "_io_en"}, 0, int'(io_en));
        check_value({name, "_rd_led"}, 0, int'(rd_done_led));
        check_value({name, "_wt_led"}, 0, int'(wt_done_led));
        check_value({name, "_txd"}, 1, int'(uart_txd));
    endtask

    task automatic pulse_rd_done();
        rd_done = 1'b1;
        @(negedge clk_100m);
        rd_done = 1'b0;
    endtask

    task automatic pulse_wt_done();
        wt_done = 1'b1;
        @(negedge clk_100m);
        wt_done = 1'b0;
    endtask

    // One report, optionally with a second rd_done while it runs
    task automatic run_report(input string name, input bit extra_rd_done);
        int base;
        base = rx_q.size();
        for (int c = 0; c < `BOARD_NUM_CHIPS; c++) begin
            dram_data[CHIP_W'(c)] = 8'($random(seed));
        end
        pulse_rd_done();
        if (extra_rd_done) begin
            wait_cycles(20);
            pulse_rd_done();
        end
        while (rx_q.size() < base + REPORT_BYTES) begin
            @(negedge clk_100m);
        end
        // Long enough for a stray extra frame to show up
        wait_cycles(12 * BAUD_DIV);
        check_value({name, "_byte_count"}, REPORT_BYTES, rx_q.size() - base);
        for (int c = 0; c < `BOARD_NUM_CHIPS; c++) begin
            check_value($sformatf("%s_chip%0d", name, c + 1),
                        int'(dram_data[CHIP_W'(c)]), int'(rx_q[base + 2 * c]));
            check_value($sformatf("%s_newline%0d", name, c + 1),
                        int'(`BOARD_NEWLINE), int'(rx_q[base + 2 * c + 1]));
        end
        check_value({name, "_txd_idle"}, 1, int'(uart_txd));
    endtask

    initial begin
        int total;
        seed         = 32'h03ac_4e6a;
        rst_n_locked = 1'b0;
        io_en_button = 1'b1;
        rd_done      = 1'b0;
        wt_done      = 1'b0;
        dram_data    = '0;
        repeat (3) @(negedge clk_100m);
        check_idle_outputs("in_reset");
        rst_n_locked = 1'b1;
        @(negedge clk_100m);
        check_idle_outputs("after_reset");

        // Too short to pass the debouncer
        io_en_button = 1'b0;
        wait_cycles(DEBOUNCE_CYCLES - 4);
        io_en_button = 1'b1;
        wait_cycles(2 * DEBOUNCE_CYCLES);
        check_value("glitch_io_en_pulses", 0, io_en_cnt);

        io_en_button = 1'b0;
        wait_cycles(DEBOUNCE_CYCLES + 8);
        io_en_button = 1'b1;
        wait_cycles(2 * DEBOUNCE_CYCLES);
        check_value("press_io_en_pulses", 1, io_en_cnt);

        // Retrigger halfway through the hold
        pulse_wt_done();
        wait_cycles(HOLD_CYCLES / 2);
        pulse_wt_done();
        wait_cycles(HOLD_CYCLES + 10);
        check_value("wt_led_released", 0, int'(wt_done_led));

        run_report("report1", 1'b1);
        run_report("report2", 1'b0);
        wait_cycles(HOLD_CYCLES);

        total = stim_errs + led_errs + rx_errs + pulse_errs + strobe_errs;
        $display("Errors: checks %0d, leds %0d, frames %0d, properties %0d, total %0d",
                 stim_errs, led_errs, rx_errs, pulse_errs + strobe_errs, total);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+hw
hw/board_pkg.sv
hw/uart_pkg.sv
hw/btn_debounce.sv
hw/done_led_hold.sv
hw/report_sequencer.sv
hw/uart_tx.sv
hw/board_ctrl_top.sv
dv/uart_line_monitor.sv
dv/tb_board_ctrl.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_board_ctrl -f project.f -o sim_board_ctrl

./obj_dir/sim_board_ctrl > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation PASSED"
